/* flist.f */
+incdir+verilog
verilog/axi_mem_pkg.sv
verilog/line_store.sv
verilog/axi_wr_ctrl.sv
verilog/axi_bresp_queue.sv
verilog/axi_rd_ctrl.sv
verilog/axi_mem_top.sv
verif/axi_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f flist.f --top-module axi_mem_tb

# the log decides pass or fail, so a nonzero exit from the run is tolerated here
./obj_dir/Vaxi_mem_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
grep -q "Result: PASSED" sim.log

/* verif/axi_mem_tb.sv */
`include "axi_mem_defs.svh"

module axi_mem_tb import axi_mem_pkg::*; ();

	localparam logic [31:0] SEED = 32'hb1a10ea4;
	localparam int N_EMPTY = 4;
	localparam int N_FULL = 8;
	localparam int N_RAND = 60;
	localparam int N_BP = `BRESP_DEPTH + 1;
	// each write and each read is one transaction
	localparam int N_TXN = N_EMPTY + 2 * N_FULL + N_RAND + 2 * N_BP;

	logic clk;
	logic rst_n;
	logic aw_valid;
	logic aw_ready;
	aw_req_t aw;
	logic w_valid;
	logic w_ready;
	w_beat_t w;
	logic b_valid;
	logic b_ready;
	b_rsp_t b;
	logic ar_valid;
	logic ar_ready;
	ar_req_t ar;
	logic r_valid;
	logic r_ready;
	r_beat_t r;

	logic [31:0] seed;
	logic [31:0] stall_seed;
	logic hold_b = 1'b0;
	id_t exp_b [$];
	// reference memory over the 16 lines in use
	data_t model_mem [16][2];
	logic model_vld [16];

	axi_mem_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] rand32();
		seed = lcg(seed);
		return seed;
	endfunction

	function automatic data_t rand_data();
		data_t d;
		for (int i = 0; i < 8; i++) begin
			d[32*i +: 32] = rand32();
		end
		return d;
	endfunction

	// all ones, none, lower half, upper half or random
	function automatic strb_t pick_strb();
		case ((rand32() >> 16) % 5)
			0: return '1;
			1: return '0;
			2: return 32'h0000_ffff;
			3: return 32'hffff_0000;
			default: return rand32();
		endcase
	endfunction

	// a fresh line starts as zeros, then strobed bytes replace old ones
	function automatic void model_write(int line, int beat, data_t d, strb_t s);
		if (!model_vld[line]) begin
			model_mem[line][0] = '0;
			model_mem[line][1] = '0;
			model_vld[line] = 1'b1;
		end
		for (int i = 0; i < `AXI_STRB_W; i++) begin
			if (s[i]) begin
				model_mem[line][beat][8*i +: 8] = d[8*i +: 8];
			end
		end
	endfunction

	function automatic data_t model_read(int line, int beat);
		return model_vld[line] ? model_mem[line][beat] : '0;
	endfunction

	task automatic expect_eq(input string name, input logic [255:0] exp,
			input logic [255:0] act);
		assert (act === exp) else begin
			$display("FAILED %s expected %h actual %h", name, exp, act);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	task automatic ensure(input logic cond, input string what);
		assert (cond) else begin
			$display("error: %s", what);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic pick_txn(output id_t id, output int line, output logic len);
		id = id_t'(rand32() >> 16);
		line = int'((rand32() >> 16) % 16);
		len = 1'(rand32() >> 31);
	endtask

	task automatic send_write(input id_t id, input int line, input logic len,
			input logic full);
		data_t d;
		strb_t s;
		logic hs;
		aw_valid = 1'b1;
		aw.id = id;
		aw.addr = addr_t'(line) << `LINE_OFS;
		// only len bit 0 matters to the DUT
		aw.len = {7'(rand32() >> 25), len};
		do begin
			@(negedge clk);
			hs = aw_ready;
			next_cycle();
		end while (!hs);
		aw_valid = 1'b0;
		exp_b.push_back(id);
		for (int k = 0; k <= int'(len); k++) begin
			d = rand_data();
			s = full ? '1 : pick_strb();
			w_valid = 1'b1;
			w.data = d;
			w.strb = s;
			do begin
				@(negedge clk);
				hs = w_ready;
				next_cycle();
			end while (!hs);
			model_write(line, k, d, s);
		end
		w_valid = 1'b0;
	endtask

	task automatic send_read(input id_t id, input int line, input logic len);
		logic hs;
		logic held;
		logic done;
		r_beat_t held_r;
		int beat;
		int cyc;
		ar_valid = 1'b1;
		ar.id = id;
		ar.addr = addr_t'(line) << `LINE_OFS;
		ar.len = {7'(rand32() >> 25), len};
		do begin
			@(negedge clk);
			hs = ar_ready;
			next_cycle();
		end while (!hs);
		ar_valid = 1'b0;
		beat = 0;
		cyc = 0;
		held = 1'b0;
		done = 1'b0;
		while (!done) begin
			// stall about a third of the cycles
			r_ready = ((rand32() >> 16) % 3) != 0;
			@(negedge clk);
			cyc++;
			if (r_valid) begin
				if (beat == 0 && !held) begin
					expect_eq("r_latency", 2, cyc);
				end
				if (held) begin
					ensure(r === held_r, "r changed while r_ready was low");
				end
				if (r_ready) begin
					expect_eq("r_id", id, r.id);
					expect_eq("r_data", model_read(line, beat), r.data);
					expect_eq("r_resp", 0, r.resp);
					expect_eq("r_last", beat == int'(len), r.last);
					done = (beat == int'(len));
					beat++;
					held = 1'b0;
				end else begin
					held = 1'b1;
					held_r = r;
				end
			end else begin
				ensure(!held, "r_valid dropped before its handshake");
			end
			next_cycle();
		end
		r_ready = 1'b0;
		@(negedge clk);
		ensure(!r_valid, "read returned more beats than its length");
		next_cycle();
	endtask

	task automatic wait_b_drain();
		while (exp_b.size() != 0) begin
			next_cycle();
		end
		next_cycle();
	endtask

	// B sink with its own stall sequence checks IDs in write order
	initial begin
		b_ready = 1'b0;
		stall_seed = SEED;
		forever begin
			@(negedge clk);
			if (b_valid && b_ready) begin
				ensure(exp_b.size() != 0, "B response arrived with no write pending");
				expect_eq("b_id", exp_b[0], b.id);
				expect_eq("b_resp", 0, b.resp);
				void'(exp_b.pop_front());
			end
			next_cycle();
			stall_seed = lcg(stall_seed);
			b_ready = !hold_b && (stall_seed[17:16] != 2'b00);
		end
	end

	initial begin
		repeat (N_TXN * 40) @(posedge clk);
		$display("error: watchdog expired before the tests finished");
		$display("Result: FAILED");
		$fatal(1);
	end

	initial begin
		id_t id;
		int line;
		logic len;
		logic [31:0] coin;
		seed = SEED;
		for (int i = 0; i < 16; i++) begin
			model_vld[i] = 1'b0;
		end
		rst_n = 1'b0;
		aw_valid = 1'b0;
		aw = '0;
		w_valid = 1'b0;
		w = '0;
		ar_valid = 1'b0;
		ar = '0;
		r_ready = 1'b0;
		@(posedge clk);
		@(negedge clk);
		ensure(!aw_ready && !w_ready && !b_valid && !ar_ready && !r_valid,
			"an output is high during reset");
		@(posedge clk);
		#1;
		rst_n = 1'b1;
		next_cycle();
		@(negedge clk);
		ensure(aw_ready && ar_ready, "AW or AR not ready in the first cycle after reset");
		next_cycle();

		// nothing written yet, so every line reads as zero
		for (int i = 0; i < N_EMPTY; i++) begin
			pick_txn(id, line, len);
			send_read(id, line, len);
		end

		// full-strobe writes read back after the B response
		for (int i = 0; i < N_FULL; i++) begin
			pick_txn(id, line, len);
			send_write(id, line, len, 1'b1);
			wait_b_drain();
			pick_txn(id, coin, len);
			send_read(id, line, len);
		end

		// mix of partial writes and reads
		for (int i = 0; i < N_RAND; i++) begin
			pick_txn(id, line, len);
			coin = rand32();
			if (coin[16]) begin
				send_write(id, line, len, 1'b0);
			end else begin
				send_read(id, line, len);
			end
		end
		wait_b_drain();

		// B held off until the queue fills and AW stalls
		@(negedge clk);
		hold_b = 1'b1;
		next_cycle();
		for (int i = 0; i < `BRESP_DEPTH; i++) begin
			pick_txn(id, line, len);
			send_write(id, line, len, 1'b0);
		end
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			ensure(!aw_ready, "AW ready while the response queue is full");
			ensure(b_valid, "B not valid while responses are pending");
			expect_eq("b_head_id", exp_b[0], b.id);
			next_cycle();
		end
		@(negedge clk);
		hold_b = 1'b0;
		next_cycle();
		pick_txn(id, line, len);
		send_write(id, line, len, 1'b0);
		wait_b_drain();
		for (int i = 0; i < N_BP; i++) begin
			pick_txn(id, line, len);
			send_read(id, line, len);
		end

		@(negedge clk);
		ensure(!b_valid && exp_b.size() == 0, "B response left over at the end");
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* verilog/axi_bresp_queue.sv */
`include "axi_mem_defs.svh"

module axi_bresp_queue import axi_mem_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic push_valid,
	input id_t push_id,
	output logic full,
	output logic b_valid,
	input logic b_ready,
	output b_rsp_t b
);

	id_t fifo [`BRESP_DEPTH];
	logic [`BRESP_PTR_W-1:0] wr_ptr;
	logic [`BRESP_PTR_W-1:0] rd_ptr;
	logic [`BRESP_PTR_W:0] count;
	logic push;
	logic pop;

	assign full = (count == (`BRESP_PTR_W+1)'(`BRESP_DEPTH));
	assign push = push_valid && !full;
	assign pop = b_valid && b_ready;

	// head entry sits on B until taken
	assign b_valid = (count != '0);
	assign b.id = fifo[rd_ptr];
	assign b.resp = '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			fifo[wr_ptr] <= push_id;
		end
	end

endmodule

/* verilog/axi_mem_defs.svh */
`ifndef AXI_MEM_DEFS_SVH
`define AXI_MEM_DEFS_SVH

// one beat on the data channels
`define AXI_DATA_W 256

// one strobe bit per data byte
`define AXI_STRB_W 32

`define AXI_ID_W 6

`define AXI_ADDR_W 64

// a 64-byte line holds two beats
`define MEM_LINES 64
`define LINE_BEATS 2

// line index sits in address bits 11 to 6
`define LINE_OFS 6
`define LINE_IDX_W 6

// write response queue
`define BRESP_DEPTH 4
`define BRESP_PTR_W 2

`endif

/* verilog/axi_mem_pkg.sv */
`include "axi_mem_defs.svh"

package axi_mem_pkg;

	typedef logic [`AXI_DATA_W-1:0] data_t;
	typedef logic [`AXI_STRB_W-1:0] strb_t;
	typedef logic [`AXI_ID_W-1:0] id_t;
	typedef logic [`AXI_ADDR_W-1:0] addr_t;
	typedef logic [7:0] len_t;
	typedef logic [`LINE_IDX_W-1:0] line_idx_t;
	// always OKAY here
	typedef logic [1:0] resp_t;

	// AW and AR carry the same fields
	typedef struct packed {
		id_t id;
		addr_t addr;
		len_t len;
	} aw_req_t;

	typedef struct packed {
		id_t id;
		addr_t addr;
		len_t len;
	} ar_req_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
	} w_beat_t;

	typedef struct packed {
		id_t id;
		resp_t resp;
	} b_rsp_t;

	typedef struct packed {
		id_t id;
		data_t data;
		resp_t resp;
		logic last;
	} r_beat_t;

	// one strobed write into the line storage
	typedef struct packed {
		line_idx_t idx;
		logic beat;
		data_t data;
		strb_t strb;
	} mem_wr_t;

	typedef enum logic {
		WR_IDLE,
		WR_DATA
	} wr_state_t;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_FETCH,
		RD_SEND
	} rd_state_t;

endpackage

/* verilog/axi_mem_top.sv */
`include "axi_mem_defs.svh"

module axi_mem_top import axi_mem_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic aw_valid,
	output logic aw_ready,
	input aw_req_t aw,
	input logic w_valid,
	output logic w_ready,
	input w_beat_t w,
	output logic b_valid,
	input logic b_ready,
	output b_rsp_t b,
	input logic ar_valid,
	output logic ar_ready,
	input ar_req_t ar,
	output logic r_valid,
	input logic r_ready,
	output r_beat_t r
);

	logic mem_wr_en;
	mem_wr_t mem_wr;
	logic push_valid;
	id_t push_id;
	logic full;
	logic rd_en;
	line_idx_t rd_idx;
	data_t [`LINE_BEATS-1:0] rd_line;

	axi_wr_ctrl wr_ctrl0 (
		.clk(clk),
		.rst_n(rst_n),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.aw(aw),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.w(w),
		.full(full),
		.push_valid(push_valid),
		.push_id(push_id),
		.mem_wr_en(mem_wr_en),
		.mem_wr(mem_wr)
	);

	axi_bresp_queue bresp_q0 (
		.clk(clk),
		.rst_n(rst_n),
		.push_valid(push_valid),
		.push_id(push_id),
		.full(full),
		.b_valid(b_valid),
		.b_ready(b_ready),
		.b(b)
	);

	// read side runs independently of the write side
	axi_rd_ctrl rd_ctrl0 (
		.clk(clk),
		.rst_n(rst_n),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.ar(ar),
		.rd_en(rd_en),
		.rd_idx(rd_idx),
		.rd_line(rd_line),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.r(r)
	);

	line_store store0 (
		.clk(clk),
		.rst_n(rst_n),
		.wr_en(mem_wr_en),
		.wr(mem_wr),
		.rd_en(rd_en),
		.rd_idx(rd_idx),
		.rd_line(rd_line)
	);

endmodule

/* verilog/axi_rd_ctrl.sv */
`include "axi_mem_defs.svh"

module axi_rd_ctrl import axi_mem_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic ar_valid,
	output logic ar_ready,
	input ar_req_t ar,
	output logic rd_en,
	output line_idx_t rd_idx,
	input data_t [`LINE_BEATS-1:0] rd_line,
	output logic r_valid,
	input logic r_ready,
	output r_beat_t r
);

	rd_state_t state;
	logic live;
	logic beat;
	logic beat_last;
	id_t rd_id;
	logic ar_hs;
	logic r_hs;

	assign ar_ready = live && (state == RD_IDLE);
	assign ar_hs = ar_valid && ar_ready;
	assign r_hs = r_valid && r_ready;

	// storage read happens during fetch
	assign rd_en = (state == RD_FETCH);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= RD_IDLE;
			live <= 1'b0;
			beat <= 1'b0;
			beat_last <= 1'b0;
		end else begin
			live <= 1'b1;
			case (state)
				RD_IDLE: begin
					if (ar_hs) begin
						state <= RD_FETCH;
						beat <= 1'b0;
						beat_last <= ar.len[0];
					end
				end
				RD_FETCH: state <= RD_SEND;
				RD_SEND: begin
					if (r_hs) begin
						beat <= beat + 1'b1;
						if (beat == beat_last) begin
							state <= RD_IDLE;
						end
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rd_id <= ar.id;
			rd_idx <= ar.addr[`LINE_OFS +: `LINE_IDX_W];
		end
	end

	// rd_line only moves in fetch, so r stays put under back-pressure
	assign r_valid = (state == RD_SEND);
	assign r.id = rd_id;
	assign r.data = rd_line[beat];
	assign r.resp = '0;
	assign r.last = (beat == beat_last);

endmodule

/* verilog/axi_wr_ctrl.sv */
`include "axi_mem_defs.svh"

module axi_wr_ctrl import axi_mem_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic aw_valid,
	output logic aw_ready,
	input aw_req_t aw,
	input logic w_valid,
	output logic w_ready,
	input w_beat_t w,
	input logic full,
	output logic push_valid,
	output id_t push_id,
	output logic mem_wr_en,
	output mem_wr_t mem_wr
);

	wr_state_t state;
	logic live;
	logic beat;
	logic beat_last;
	id_t wr_id;
	line_idx_t wr_idx;
	logic aw_hs;
	logic w_hs;
	logic last_beat;

	// a full response queue holds AW off
	assign aw_ready = live && (state == WR_IDLE) && !full;
	assign w_ready = (state == WR_DATA);

	assign aw_hs = aw_valid && aw_ready;
	assign w_hs = w_valid && w_ready;

	// len bit 0 picks one or two beats
	assign last_beat = (beat == beat_last);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= WR_IDLE;
			live <= 1'b0;
			beat <= 1'b0;
			beat_last <= 1'b0;
		end else begin
			live <= 1'b1;
			case (state)
				WR_IDLE: begin
					if (aw_hs) begin
						state <= WR_DATA;
						beat <= 1'b0;
						beat_last <= aw.len[0];
					end
				end
				WR_DATA: begin
					if (w_hs) begin
						beat <= beat + 1'b1;
						if (last_beat) begin
							state <= WR_IDLE;
						end
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs) begin
			wr_id <= aw.id;
			wr_idx <= aw.addr[`LINE_OFS +: `LINE_IDX_W];
		end
	end

	// each accepted beat goes straight to storage
	always_comb begin
		mem_wr_en = w_hs;
		mem_wr.idx = wr_idx;
		mem_wr.beat = beat;
		mem_wr.data = w.data;
		mem_wr.strb = w.strb;
	end

	assign push_valid = w_hs && last_beat;
	assign push_id = wr_id;

endmodule

/* verilog/line_store.sv */
`include "axi_mem_defs.svh"

module line_store import axi_mem_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic wr_en,
	input mem_wr_t wr,
	input logic rd_en,
	input line_idx_t rd_idx,
	output data_t [`LINE_BEATS-1:0] rd_line
);

	data_t mem [`MEM_LINES][`LINE_BEATS];
	logic [`MEM_LINES-1:0] line_vld;
	data_t old_beat;
	data_t merged;

	// a line never written reads as zero
	always_comb begin
		old_beat = line_vld[wr.idx] ? mem[wr.idx][wr.beat] : '0;
		for (int b = 0; b < `AXI_STRB_W; b++) begin
			merged[8*b +: 8] = wr.strb[b] ? wr.data[8*b +: 8] : old_beat[8*b +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			line_vld <= '0;
		end else if (wr_en) begin
			line_vld[wr.idx] <= 1'b1;
		end
	end

	// first write to a line also clears its other beat
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int k = 0; k < `LINE_BEATS; k++) begin
				if (wr.beat == 1'(k)) begin
					mem[wr.idx][k] <= merged;
				end else if (!line_vld[wr.idx]) begin
					mem[wr.idx][k] <= '0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			for (int k = 0; k < `LINE_BEATS; k++) begin
				rd_line[k] <= line_vld[rd_idx] ? mem[rd_idx][k] : '0;
			end
		end
	end

endmodule
